/* hw/common_pkg.sv */
package common;

        typedef enum logic [2:0]
        {
                R_TYPE,
                I_TYPE,
                S_TYPE,
                B_TYPE,
                U_TYPE,
                J_TYPE,
                ILLEGAL
        } instruction_op_type;

        typedef enum logic [2:0]
        {
                WB_ALU,
                WB_MEM,
                WB_PC4,
                WB_IMM,
                WB_PCIMM
        } wb_sel_t;

        localparam logic [6:0] OP      = 7'b0110011;
        localparam logic [6:0] OP_IMM  = 7'b0010011;
        localparam logic [6:0] LOAD    = 7'b0000011;
        localparam logic [6:0] LOAD_FP = 7'b0000111;
        localparam logic [6:0] STORE   = 7'b0100011;
        localparam logic [6:0] BRANCH  = 7'b1100011;
        localparam logic [6:0] JAL     = 7'b1101111;
        localparam logic [6:0] JALR    = 7'b1100111;
        localparam logic [6:0] U_LUI   = 7'b0110111;
        localparam logic [6:0] U_AUIPC = 7'b0010111;

        localparam logic [2:0] BEQ  = 3'b000;
        localparam logic [2:0] BNE  = 3'b001;
        localparam logic [2:0] BLT  = 3'b100;
        localparam logic [2:0] BGE  = 3'b101;
        localparam logic [2:0] BLTU = 3'b110;
        localparam logic [2:0] BGEU = 3'b111;

        localparam logic [2:0] F3_ADD  = 3'b000; // add/sub
        localparam logic [2:0] F3_SLL  = 3'b001;
        localparam logic [2:0] F3_SLT  = 3'b010;
        localparam logic [2:0] F3_SLTU = 3'b011;
        localparam logic [2:0] F3_XOR  = 3'b100;
        localparam logic [2:0] F3_SR   = 3'b101; // srl/sra
        localparam logic [2:0] F3_OR   = 3'b110;
        localparam logic [2:0] F3_AND  = 3'b111;

endpackage

/* hw/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder import common::*; (
        input  logic [31:0]        instr,
        output logic [6:0]         opcode,
        output logic [4:0]         rd,
        output logic [4:0]         rs1,
        output logic [4:0]         rs2,
        output logic [2:0]         funct3,
        output logic               funct7_alt,
        output instruction_op_type optype,
        output logic [31:0]        imm
);

assign opcode     = instr[6:0];
assign rd         = instr[11:7];
assign funct3     = instr[14:12];
assign rs1        = instr[19:15];
assign rs2        = instr[24:20];
assign funct7_alt = instr[30]; // sub / sra select

always_comb
begin
        case (opcode)
                OP:
                        optype = R_TYPE;
                OP_IMM, LOAD, JALR:
                        optype = I_TYPE;
                STORE:
                        optype = S_TYPE;
                BRANCH:
                        optype = B_TYPE;
                U_LUI, U_AUIPC:
                        optype = U_TYPE;
                JAL:
                        optype = J_TYPE;
                LOAD_FP:
                        optype = ILLEGAL; // no fp unit
                default:
                        optype = ILLEGAL;
        endcase
end

always_comb
begin
        case (optype)
                I_TYPE:
                        imm = {{20{instr[31]}}, instr[31:20]};
                S_TYPE:
                        imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                B_TYPE:
                        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                               instr[11:8], 1'b0};
                U_TYPE:
                        imm = {instr[31:12], 12'b0};
                J_TYPE:
                        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                               instr[30:21], 1'b0};
                default:
                        imm = '0;
        endcase
end

endmodule

/* hw/control_unit.sv */
`timescale 1ns/1ps

module control_unit import common::*; (
        input  logic [6:0]         opcode,
        input  instruction_op_type optype,
        input  logic [2:0]         funct3,
        input  logic [31:0]        rs1_data,
        input  logic [31:0]        rs2_data,

        output logic               ctrl_mem_write,
        output wb_sel_t            ctrl_wb_sel,
        output logic               ctrl_reg_write,
        output logic               ctrl_alu_src,
        output logic               ctrl_alu_imm_op,
        output logic               ctrl_is_branch,
        output logic               ctrl_branch_taken
);

logic eq_flag;
logic lt_flag;
logic ltu_flag;

assign eq_flag  = (rs1_data == rs2_data);
assign lt_flag  = ($signed(rs1_data) < $signed(rs2_data));
assign ltu_flag = (rs1_data < rs2_data); // unsigned compare

always_comb
begin
        ctrl_mem_write    = 1'b0;
        ctrl_wb_sel       = WB_ALU;
        ctrl_reg_write    = 1'b0;
        ctrl_alu_src      = 1'b0;
        ctrl_alu_imm_op   = 1'b0;
        ctrl_is_branch    = 1'b0;
        ctrl_branch_taken = 1'b0;

        case (optype)
                R_TYPE:
                        ctrl_reg_write = 1'b1;
                I_TYPE:
                begin
                        ctrl_reg_write  = 1'b1;
                        ctrl_alu_src    = 1'b1;
                        ctrl_alu_imm_op = (opcode == OP_IMM);
                        if (opcode == LOAD)
                        begin
                                ctrl_wb_sel = WB_MEM;
                        end
                        else if (opcode == JALR)
                        begin
                                ctrl_wb_sel       = WB_PC4; // link
                                ctrl_is_branch    = 1'b1;
                                ctrl_branch_taken = 1'b1;
                        end
                end
                S_TYPE:
                begin
                        ctrl_alu_src   = 1'b1;
                        ctrl_mem_write = 1'b1;
                end
                B_TYPE:
                begin
                        ctrl_is_branch = 1'b1;
                        case (funct3)
                                BEQ:     ctrl_branch_taken = eq_flag;
                                BNE:     ctrl_branch_taken = !eq_flag;
                                BLT:     ctrl_branch_taken = lt_flag;
                                BGE:     ctrl_branch_taken = !lt_flag;
                                BLTU:    ctrl_branch_taken = ltu_flag;
                                BGEU:    ctrl_branch_taken = !ltu_flag;
                                default: ctrl_branch_taken = 1'b0; // reserved funct3
                        endcase
                end
                U_TYPE:
                begin
                        ctrl_reg_write = 1'b1;
                        ctrl_wb_sel    = (opcode == U_LUI) ? WB_IMM : WB_PCIMM;
                end
                J_TYPE:
                begin
                        ctrl_reg_write    = 1'b1;
                        ctrl_wb_sel       = WB_PC4;
                        ctrl_is_branch    = 1'b1;
                        ctrl_branch_taken = 1'b1;
                end
                default:
                        ; // illegal, behaves as nop
        endcase
end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps

module reg_file #(
        parameter int reg_count = 32
) (
        input  logic        clk,
        input  logic        rst_n,
        input  logic [4:0]  rs1,
        input  logic [4:0]  rs2,
        input  logic [4:0]  rd,
        input  logic        we,
        input  logic [31:0] wdata,
        output logic [31:0] rs1_data,
        output logic [31:0] rs2_data
);

localparam int aw = $clog2(reg_count);

logic [31:0] regs [reg_count];

always_ff @(posedge clk or negedge rst_n)
begin
        if (!rst_n)
        begin
                for (int i = 0; i < reg_count; i++)
                        regs[i] <= '0;
        end
        else if (we && rd != 5'd0 && rd < reg_count)
        begin
                regs[rd[aw-1:0]] <= wdata;
        end
end

assign rs1_data = (rs1 == 5'd0 || rs1 >= reg_count) ? '0 : regs[rs1[aw-1:0]];
assign rs2_data = (rs2 == 5'd0 || rs2 >= reg_count) ? '0 : regs[rs2[aw-1:0]];

endmodule

/* hw/alu.sv */
`timescale 1ns/1ps

module alu import common::*; (
        input  logic [31:0] a,
        input  logic [31:0] b,
        input  logic [2:0]  funct3,
        input  logic        alt,
        input  logic        imm_op,
        output logic [31:0] y
);

logic [4:0] shamt;

assign shamt = b[4:0];

always_comb
begin
        case (funct3)
                F3_ADD:
                begin
                        if (alt && !imm_op) // addi has no sub form
                                y = a - b;
                        else
                                y = a + b;
                end
                F3_SLL:
                        y = a << shamt;
                F3_SLT:
                        y = {31'b0, $signed(a) < $signed(b)};
                F3_SLTU:
                        y = {31'b0, a < b};
                F3_XOR:
                        y = a ^ b;
                F3_SR:
                begin
                        if (alt)
                                y = $unsigned($signed(a) >>> shamt);
                        else
                                y = a >> shamt;
                end
                F3_OR:
                        y = a | b;
                default:
                        y = a & b;
        endcase
end

endmodule

/* hw/core_top.sv */
`timescale 1ns/1ps

module core_top import common::*; #(
        parameter int reg_count = 32
) (
        input  logic        clk,
        input  logic        rst_n,
        output logic [31:0] pc,
        input  logic [31:0] instr,
        output logic [31:0] dmem_addr,
        output logic [31:0] dmem_wdata,
        output logic        dmem_we,
        input  logic [31:0] dmem_rdata
);

logic [6:0]         opcode;
logic [4:0]         rd;
logic [4:0]         rs1;
logic [4:0]         rs2;
logic [2:0]         funct3;
logic               funct7_alt;
instruction_op_type optype;
logic [31:0]        imm;

logic [31:0] rs1_data;
logic [31:0] rs2_data;

logic        ctrl_mem_write;
wb_sel_t     ctrl_wb_sel;
logic        ctrl_reg_write;
logic        ctrl_alu_src;
logic        ctrl_alu_imm_op;
logic        ctrl_is_branch;
logic        ctrl_branch_taken;

logic        force_add;
logic [2:0]  alu_funct3;
logic        alu_alt;
logic [31:0] alu_b;
logic [31:0] alu_y;
logic [31:0] pc_plus4;
logic [31:0] pc_imm;
logic [31:0] next_pc;
logic [31:0] wb_data;

instr_decoder u_dec (.instr, .opcode, .rd, .rs1, .rs2, .funct3, .funct7_alt, .optype, .imm);

reg_file #(.reg_count(reg_count)) u_rf (
        .clk, .rst_n, .rs1, .rs2, .rd,
        .we    (ctrl_reg_write & rst_n),
        .wdata (wb_data),
        .rs1_data, .rs2_data
);

control_unit u_ctrl (
        .opcode, .optype, .funct3, .rs1_data, .rs2_data,
        .ctrl_mem_write, .ctrl_wb_sel, .ctrl_reg_write, .ctrl_alu_src,
        .ctrl_alu_imm_op, .ctrl_is_branch, .ctrl_branch_taken
);

// address generation always adds
assign force_add  = (opcode == LOAD) || (opcode == STORE) || (opcode == JALR) ||
                    (opcode == U_AUIPC);
assign alu_funct3 = force_add ? F3_ADD : funct3;
assign alu_alt    = force_add ? 1'b0 : funct7_alt;
assign alu_b      = ctrl_alu_src ? imm : rs2_data;

alu u_alu (.a(rs1_data), .b(alu_b), .funct3(alu_funct3), .alt(alu_alt),
           .imm_op(ctrl_alu_imm_op), .y(alu_y));

assign pc_plus4 = pc + 32'd4;
assign pc_imm   = pc + imm;

always_comb
begin
        if (ctrl_is_branch && ctrl_branch_taken)
                next_pc = (opcode == JALR) ? {alu_y[31:1], 1'b0} : pc_imm;
        else
                next_pc = pc_plus4;
end

always_ff @(posedge clk or negedge rst_n)
begin
        if (!rst_n)
                pc <= '0;
        else
                pc <= next_pc;
end

always_comb
begin
        case (ctrl_wb_sel)
                WB_MEM:   wb_data = dmem_rdata;
                WB_PC4:   wb_data = pc_plus4;
                WB_IMM:   wb_data = imm; // lui
                WB_PCIMM: wb_data = pc_imm; // auipc
                default:  wb_data = alu_y;
        endcase
end

assign dmem_addr  = alu_y;
assign dmem_wdata = rs2_data;
assign dmem_we    = ctrl_mem_write & rst_n; // no stores in reset

endmodule

/* tests/core_sva.sv */
`timescale 1ns/1ps

module core_sva import common::*; (
        input logic        clk,
        input logic        rst_n,
        input logic [31:0] pc,
        input logic [31:0] instr,
        input logic        dmem_we
);

int   fail_count = 0;
logic redirect;

assign redirect = (instr[6:0] == BRANCH) || (instr[6:0] == JAL) || (instr[6:0] == JALR);

task automatic flag_failure(input string what);
        $error("%s", what);
        fail_count++;
endtask

pc_increments: assert property (@(posedge clk) disable iff (!rst_n)
        !redirect |=> pc == $past(pc) + 32'd4)
        else flag_failure("pc did not advance by 4 after a sequential instruction");
pc_aligned: assert property (@(posedge clk) pc[1:0] == 2'b00)
        else flag_failure("pc is not word aligned");
store_enable: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_we == (instr[6:0] == STORE))
        else flag_failure("dmem_we does not match a store opcode");
pc_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> pc == 32'd0)
        else flag_failure("pc not zero in the first cycle after reset");
no_store_in_reset: assert property (@(posedge clk) !rst_n |-> !dmem_we)
        else flag_failure("dmem_we high during reset");

endmodule

bind core_top core_sva u_sva (.clk, .rst_n, .pc, .instr, .dmem_we);

/* tests/tb_core.sv */
`timescale 1ns/1ps

module tb_core import common::*; ();

localparam int max_cycles = 200; // ~49 program words plus reset, with margin

logic        clk;
logic        rst_n;
logic        dmem_we;
logic [31:0] pc, instr, dmem_addr, dmem_wdata, dmem_rdata;
logic [31:0] imem [256];
logic [31:0] dmem [256];
logic [31:0] expected [256];
int          n, i, jal_at, loop_at;
int          cycles = 0;

core_top #(.reg_count(32)) uut (
        .clk, .rst_n, .pc, .instr, .dmem_addr, .dmem_wdata, .dmem_we, .dmem_rdata
);

always #5 clk = ~clk;

assign instr      = imem[pc[9:2]];
assign dmem_rdata = dmem[dmem_addr[9:2]];

always @(posedge clk)
begin
        if (dmem_we)
                dmem[dmem_addr[9:2]] <= dmem_wdata;
end

function automatic logic [31:0] r_format(input logic [2:0] f3, input logic alt,
                                         input logic [4:0] rd, rs1, rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP};
endfunction

function automatic logic [31:0] i_format(input logic [6:0] op, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, input int imm);
        return {imm[11:0], rs1, f3, rd, op};
endfunction

function automatic logic [31:0] s_format(input logic [4:0] rs2, rs1, input int off);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], STORE};
endfunction

task automatic append(input logic [31:0] word);
        imem[n] = word;
        n++;
endtask

task automatic op_and_store(input logic [31:0] word, input logic [4:0] rd, input int slot,
                            input logic [31:0] value);
        append(word);
        append(s_format(rd, 5'd0, 4 * slot));
        expected[slot] = value;
endtask

// not-taken branch, then a taken one over a wrong-path store to word 7
task automatic branch_pair(input logic [2:0] f3, input logic [4:0] nt_a, nt_b, tk_a, tk_b);
        append({7'd0, nt_b, nt_a, f3, 5'b01000, BRANCH}); // offset +8
        append({7'd0, tk_b, tk_a, f3, 5'b01000, BRANCH});
        append(s_format(5'd3, 5'd0, 28));
endtask

task automatic check_word(input int idx, input logic [31:0] exp);
        assert (dmem[idx] === exp)
        else
        begin
                $display("FAILED at %0t: dmem[%0d] = %h, expected %h",
                         $time, idx, dmem[idx], exp);
                $display("** FAIL **");
                $fatal(1, "data memory mismatch");
        end
endtask

always @(negedge clk)
begin
        cycles++;
        if (cycles > max_cycles)
        begin
                $display("timeout: core did not reach its final loop in %0d cycles", max_cycles);
                $display("** FAIL **");
                $fatal(1, "timeout");
        end
        else if (uut.u_sva.fail_count != 0)
        begin
                $display("a bound assertion on the core failed");
                $display("** FAIL **");
                $fatal(1, "assertion failure");
        end
end

initial
begin
        clk   = 1'b0;
        rst_n = 1'b0;
        n     = 0;
        for (i = 0; i < 256; i++)
        begin
                dmem[i]     <= 32'hbeef0000 | 32'(i); // tagged with its own index
                expected[i]  = 32'hbeef0000 | 32'(i);
        end
        append(s_format(0, 0, 52)); // store seen at pc 0 while in reset
        expected[13] = 32'd0;
        append({20'h80000, 5'd1, U_LUI});
        append(i_format(OP_IMM, F3_ADD, 2, 0, -5));
        append(i_format(OP_IMM, F3_ADD, 3, 0, 3));
        op_and_store({20'h00001, 5'd4, U_AUIPC}, 4, 0, 32'(4 * n) + 32'h1000);
        op_and_store(r_format(F3_ADD, 1'b1, 5, 3, 2), 5, 1, 32'd8); // 3 - (-5)
        op_and_store(r_format(F3_SR, 1'b1, 6, 2, 3), 6, 2, 32'hffffffff); // sign fills
        op_and_store(r_format(F3_SR, 1'b0, 7, 2, 3), 7, 3, 32'h1fffffff);
        op_and_store(r_format(F3_SLT, 1'b0, 8, 2, 3), 8, 4, 32'd1);
        op_and_store(r_format(F3_SLTU, 1'b0, 9, 2, 3), 9, 5, 32'd0);
        op_and_store(i_format(OP_IMM, F3_SR, 10, 1, 'h404), 10, 6, 32'hf8000000); // srai 4
        branch_pair(BEQ, 2, 3, 3, 3);
        branch_pair(BNE, 3, 3, 2, 3);
        branch_pair(BLT, 3, 2, 2, 3);
        branch_pair(BGE, 2, 3, 3, 2);
        branch_pair(BLTU, 2, 3, 3, 2);
        branch_pair(BGEU, 3, 2, 2, 3);
        jal_at = n;
        append({1'b0, 10'd4, 1'b0, 8'd0, 5'd14, JAL}); // jal x14, +8
        append(s_format(3, 0, 28));
        append(i_format(JALR, 3'b000, 15, 14, 13)); // odd target, bit 0 dropped
        append(s_format(3, 0, 28));
        append(s_format(14, 0, 32));
        append(s_format(15, 0, 36));
        expected[8] = 32'(4 * jal_at + 4);
        expected[9] = 32'(4 * jal_at + 12);
        append(i_format(OP_IMM, F3_ADD, 16, 0, 32));
        append(s_format(1, 16, 8)); // word 10 via x16
        append(i_format(LOAD, 3'b010, 17, 0, 40));
        append(s_format(17, 0, 44));
        append(i_format(OP_IMM, F3_ADD, 0, 0, 123));
        append(s_format(0, 0, 48));
        expected[10] = 32'h80000000;
        expected[11] = 32'h80000000;
        expected[12] = 32'd0;
        loop_at = n;
        append({25'd0, JAL}); // jal x0, 0

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        while (pc !== 32'(4 * loop_at))
                @(negedge clk);
        @(negedge clk);
        for (i = 0; i < 256; i++)
                check_word(i, expected[i]);
        if (uut.u_sva.fail_count != 0)
        begin
                $display("a bound assertion on the core failed");
                $display("** FAIL **");
                $fatal(1, "assertion failure");
        end
        else
        begin
                $display("** PASS **");
                $finish;
        end
end

endmodule

/* vlog.f */
hw/common_pkg.sv
hw/instr_decoder.sv
hw/control_unit.sv
hw/reg_file.sv
hw/alu.sv
hw/core_top.sv
tests/core_sva.sv
tests/tb_core.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --assert --timing -Wno-fatal
TOP       = tb_core
FILELIST  = vlog.f
LOG       = sim.log

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only --assert --timing -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim: build
	./obj_dir/V$(TOP) +verilator+error+limit+10 | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
